/* Makefile */
# Verilator flow for the coprocessor subsystem testbench

TOP := tb_fpu_ss

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
logic/fpu_ss_pkg.sv
logic/fpu_ss_buffer.sv
logic/fpu_ss_controller.sv
logic/fpu_ss_exec_unit.sv
logic/fpu_ss_regfile.sv
logic/fpu_ss.sv
dv/fpu_ss_clkgen.sv
dv/tb_fpu_ss.sv

/* dv/fpu_ss_clkgen.sv */
/*
 * Testbench clock and reset source. Clock period is 8 time units.
 * Reset is held low for the first 16 rising edges, then released.
 */
`default_nettype none

module fpu_ss_clkgen (
    output logic clk_o,
    output logic rst_no
);

    // Free-running clock, 4 units high and 4 units low
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

    // Release on a falling edge so no rising edge sees reset change
    initial begin
        rst_no = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule : fpu_ss_clkgen

`default_nettype wire

/* dv/tb_fpu_ss.sv */
/*
 * Random testbench for the coprocessor subsystem, seed 43.
 * Inputs change on falling edges, outputs are sampled on rising edges.
 * The reference model assumes DATA_W is 32 and in-order retirement.
 */
`default_nettype none

module tb_fpu_ss;

    localparam int unsigned BUF_DEPTH  = 4;
    localparam int unsigned NUM_RANDOM = 300;
    // Each readback, burst and random instruction gets 20 cycles on top of reset
    localparam int unsigned TIMEOUT_CYCLES = (8 + 2 * BUF_DEPTH + NUM_RANDOM) * 20 + 16;
    // A full buffer drains well within this many cycles even with a random host
    localparam int unsigned DRAIN_CYCLES = 40 * BUF_DEPTH;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          in_valid_i;
    logic                          in_ready_o;
    fpu_ss_pkg::op_e               in_op_i;
    logic [fpu_ss_pkg::REG_AW-1:0] in_rd_i;
    logic [fpu_ss_pkg::REG_AW-1:0] in_rs1_i;
    logic [fpu_ss_pkg::REG_AW-1:0] in_rs2_i;
    logic [fpu_ss_pkg::DATA_W-1:0] in_data_i;
    logic                          resp_valid_o;
    logic                          resp_ready_i;
    logic [fpu_ss_pkg::DATA_W-1:0] resp_data_o;
    logic [fpu_ss_pkg::REG_AW-1:0] resp_rd_o;

    // Reference state is updated in program order at each accepted push
    logic [fpu_ss_pkg::DATA_W-1:0] model_regs [8];
    logic [fpu_ss_pkg::DATA_W-1:0] exp_data [$];
    logic [fpu_ss_pkg::REG_AW-1:0] exp_rd [$];

    int unsigned cycles;
    int unsigned value_errs;
    int unsigned other_errs;
    int unsigned accepted;
    int unsigned resp_seen;
    int unsigned resp_expected;
    // Set while every accepted instruction is response-type, so that
    // accepted minus responses is the exact outstanding count
    logic        exact_count;
    logic        held_q;
    logic [fpu_ss_pkg::DATA_W-1:0] held_data;
    logic [fpu_ss_pkg::REG_AW-1:0] held_rd;
    // 0 keeps resp_ready_i high, 1 holds it low, 2 randomizes it
    int unsigned ready_mode;
    int unsigned stall_cycles;
    logic        saw_full;

    fpu_ss_clkgen i_clkgen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    fpu_ss #(
        .BUF_DEPTH (BUF_DEPTH)
    ) UUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_rd_i      (in_rd_i),
        .in_rs1_i     (in_rs1_i),
        .in_rs2_i     (in_rs2_i),
        .in_data_i    (in_data_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_data_o  (resp_data_o),
        .resp_rd_o    (resp_rd_o)
    );

    // Expected result of one operation by the integer rules of the unit
    function automatic logic [31:0] expected_result(input fpu_ss_pkg::op_e op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b,
                                                    input logic [31:0] d);
        case (op)
            fpu_ss_pkg::OP_ADD:  return a + b;
            fpu_ss_pkg::OP_SUB:  return a - b;
            fpu_ss_pkg::OP_MIN:  return ($signed(a) <= $signed(b)) ? a : b;
            fpu_ss_pkg::OP_MAX:  return ($signed(a) >= $signed(b)) ? a : b;
            fpu_ss_pkg::OP_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fpu_ss_pkg::OP_MVWX: return d;
            fpu_ss_pkg::OP_MVXW: return a;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic writes_reg(input fpu_ss_pkg::op_e op);
        return (op == fpu_ss_pkg::OP_ADD) || (op == fpu_ss_pkg::OP_SUB) ||
               (op == fpu_ss_pkg::OP_MIN) || (op == fpu_ss_pkg::OP_MAX) ||
               (op == fpu_ss_pkg::OP_MVWX);
    endfunction

    function automatic logic returns_value(input fpu_ss_pkg::op_e op);
        return (op == fpu_ss_pkg::OP_MVXW) || (op == fpu_ss_pkg::OP_LT);
    endfunction

    task automatic print_summary();
        $display("Summary: %0d value errors, %0d other errors, %0d of %0d responses seen",
                 value_errs, other_errs, resp_seen, resp_expected);
    endtask

    // Move to the falling edge of the next cycle and set resp_ready_i for it
    task automatic next_cycle();
        @(negedge clk_i);
        // Burst mode lets the host accept again once the buffer has stalled
        if (ready_mode == 1 && stall_cycles >= 4) begin
            ready_mode = 2;
        end
        case (ready_mode)
            0:       resp_ready_i = 1'b1;
            1:       resp_ready_i = 1'b0;
            default: resp_ready_i = ($urandom_range(0, 3) != 0);
        endcase
    endtask

    task automatic idle_cycle();
        next_cycle();
        in_valid_i = 1'b0;
    endtask

    // Hold one instruction on the issue port until the buffer takes it
    task automatic send_instr(input fpu_ss_pkg::op_e op,
                              input logic [2:0] rd,
                              input logic [2:0] rs1,
                              input logic [2:0] rs2,
                              input logic [31:0] data);
        next_cycle();
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_rd_i    = rd;
        in_rs1_i   = rs1;
        in_rs2_i   = rs2;
        in_data_i  = data;
        @(posedge clk_i);
        while (!in_ready_o) begin
            saw_full = 1'b1;
            stall_cycles++;
            next_cycle();
            @(posedge clk_i);
        end
    endtask

    task automatic send_random();
        int unsigned     pick;
        fpu_ss_pkg::op_e op;
        logic [31:0]     data;
        pick = $urandom_range(0, 9);
        // Extra weight on readbacks so register writes get observed
        op = (pick >= 8) ? fpu_ss_pkg::OP_MVXW : fpu_ss_pkg::op_e'(3'(pick));
        data = $urandom;
        if ($urandom_range(0, 7) == 0) begin
            // Values next to the signed limits exercise wrap and compares
            data = ($urandom_range(0, 1) == 0) ? 32'h7fff_ffff : 32'h8000_0000;
        end
        send_instr(op, 3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)),
                   3'($urandom_range(0, 7)), data);
    endtask

    // Idle until every expected response is back or the drain limit passes,
    // then give the tail time to retire
    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        idle_cycle();
        while (exp_data.size() != 0 && waited < DRAIN_CYCLES) begin
            idle_cycle();
            waited++;
        end
        repeat (4) idle_cycle();
    endtask

    // The monitor samples on the rising edge where inputs and outputs are settled
    always @(posedge clk_i) begin
        logic [31:0] result;
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errs++;
            print_summary();
            $display("Test failed");
            $finish;
        end else if (rst_ni) begin
            if (exact_count && !in_ready_o && (accepted - resp_seen) < BUF_DEPTH) begin
                $display("ERROR: t=%0t in_ready_o low with only %0d outstanding",
                         $time, accepted - resp_seen);
                other_errs++;
            end
            // A stalled response must keep valid, data and rd unchanged
            if (held_q) begin
                if (resp_valid_o !== 1'b1) begin
                    $display("FAIL t=%0t resp_valid_o got %b expected 1", $time, resp_valid_o);
                    value_errs++;
                end
                if (resp_data_o !== held_data) begin
                    $display("FAIL t=%0t resp_data_o got %h expected %h",
                             $time, resp_data_o, held_data);
                    value_errs++;
                end
                if (resp_rd_o !== held_rd) begin
                    $display("FAIL t=%0t resp_rd_o got %0d expected %0d",
                             $time, resp_rd_o, held_rd);
                    value_errs++;
                end
            end
            held_q    = resp_valid_o && !resp_ready_i;
            held_data = resp_data_o;
            held_rd   = resp_rd_o;
            if (resp_valid_o && resp_ready_i) begin
                resp_seen++;
                if (exp_data.size() == 0) begin
                    $display("ERROR: t=%0t response arrived with none expected", $time);
                    other_errs++;
                end else begin
                    if (resp_data_o !== exp_data[0]) begin
                        $display("FAIL t=%0t resp_data_o got %h expected %h",
                                 $time, resp_data_o, exp_data[0]);
                        value_errs++;
                    end
                    if (resp_rd_o !== exp_rd[0]) begin
                        $display("FAIL t=%0t resp_rd_o got %0d expected %0d",
                                 $time, resp_rd_o, exp_rd[0]);
                        value_errs++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_rd.pop_front());
                end
            end
            // Accepted instructions update the model in program order
            if (in_valid_i && in_ready_o) begin
                accepted++;
                result = expected_result(in_op_i, model_regs[in_rs1_i],
                                         model_regs[in_rs2_i], in_data_i);
                if (writes_reg(in_op_i)) begin
                    model_regs[in_rd_i] = result;
                end else if (returns_value(in_op_i)) begin
                    exp_data.push_back(result);
                    exp_rd.push_back(in_rd_i);
                    resp_expected++;
                end
            end
        end
    end

    initial begin
        void'($urandom(43));
        cycles = 0;
        value_errs = 0;
        other_errs = 0;
        accepted = 0;
        resp_seen = 0;
        resp_expected = 0;
        exact_count = 1'b1;
        held_q = 1'b0;
        held_data = '0;
        held_rd = '0;
        ready_mode = 0;
        stall_cycles = 0;
        saw_full = 1'b0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        in_valid_i = 1'b0;
        in_op_i = fpu_ss_pkg::OP_ADD;
        in_rd_i = '0;
        in_rs1_i = '0;
        in_rs2_i = '0;
        in_data_i = '0;
        resp_ready_i = 1'b1;

        @(posedge rst_ni);
        @(posedge clk_i);
        if (resp_valid_o !== 1'b0) begin
            $display("FAIL t=%0t resp_valid_o got %b expected 0", $time, resp_valid_o);
            value_errs++;
        end
        if (in_ready_o !== 1'b1) begin
            $display("FAIL t=%0t in_ready_o got %b expected 1", $time, in_ready_o);
            value_errs++;
        end

        // Every register reads back zero before anything is written
        for (int r = 0; r < 8; r++) begin
            send_instr(fpu_ss_pkg::OP_MVXW, 3'(7 - r), 3'(r), 3'(0), 32'd0);
        end
        wait_drain();

        // Back-to-back readbacks with the host stalled fill the buffer
        saw_full = 1'b0;
        stall_cycles = 0;
        ready_mode = 1;
        for (int b = 0; b < 2 * BUF_DEPTH; b++) begin
            send_instr(fpu_ss_pkg::OP_MVXW, 3'($urandom_range(0, 7)),
                       3'($urandom_range(0, 7)), 3'(0), 32'd0);
        end
        wait_drain();
        exact_count = 1'b0;
        if (!saw_full) begin
            $display("ERROR: in_ready_o never went low during the stalled burst");
            other_errs++;
        end

        ready_mode = 2;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) idle_cycle();
            end
            send_random();
        end
        ready_mode = 0;
        wait_drain();

        if (exp_data.size() != 0) begin
            $display("ERROR: %0d expected responses never arrived", exp_data.size());
            other_errs++;
        end
        if (resp_seen != resp_expected) begin
            $display("ERROR: saw %0d responses for %0d response-type instructions",
                     resp_seen, resp_expected);
            other_errs++;
        end
        print_summary();
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_fpu_ss

`default_nettype wire

/* logic/fpu_ss.sv */
/*
 * Coprocessor subsystem top: buffer, controller, execution unit, registers.
 * BUF_DEPTH is a power of two, at least 2. Responses arrive in program order.
 */
`default_nettype none

module fpu_ss #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Host issue port
    input  logic                              in_valid_i,
    output logic                              in_ready_o,
    input  fpu_ss_pkg::op_e                   in_op_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     in_rd_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     in_rs1_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     in_rs2_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]     in_data_i,
    // Host response port
    output logic                              resp_valid_o,
    input  logic                              resp_ready_i,
    output logic [fpu_ss_pkg::DATA_W-1:0]     resp_data_o,
    output logic [fpu_ss_pkg::REG_AW-1:0]     resp_rd_o
);

    // Buffer head
    logic                          pop_valid;
    logic                          pop_ready;
    fpu_ss_pkg::op_e               head_op;
    logic [fpu_ss_pkg::REG_AW-1:0] head_rd;
    logic [fpu_ss_pkg::REG_AW-1:0] head_rs1;
    logic [fpu_ss_pkg::REG_AW-1:0] head_rs2;
    logic [fpu_ss_pkg::DATA_W-1:0] head_data;

    // Execution unit handshakes and result
    logic                          ex_in_valid;
    logic                          ex_in_ready;
    logic                          ex_out_valid;
    logic                          ex_out_ready;
    logic [fpu_ss_pkg::DATA_W-1:0] ex_out_data;

    // Register file ports
    logic [fpu_ss_pkg::DATA_W-1:0] rdata_a;
    logic [fpu_ss_pkg::DATA_W-1:0] rdata_b;
    logic                          fpr_we;
    logic [fpu_ss_pkg::REG_AW-1:0] fpr_waddr;

    fpu_ss_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_op_i     (in_op_i),
        .in_rd_i     (in_rd_i),
        .in_rs1_i    (in_rs1_i),
        .in_rs2_i    (in_rs2_i),
        .in_data_i   (in_data_i),
        .pop_valid_o (pop_valid),
        .pop_ready_i (pop_ready),
        .head_op_o   (head_op),
        .head_rd_o   (head_rd),
        .head_rs1_o  (head_rs1),
        .head_rs2_o  (head_rs2),
        .head_data_o (head_data)
    );

    fpu_ss_controller i_controller (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .pop_valid_i    (pop_valid),
        .pop_ready_o    (pop_ready),
        .head_op_i      (head_op),
        .head_rd_i      (head_rd),
        .ex_in_valid_o  (ex_in_valid),
        .ex_in_ready_i  (ex_in_ready),
        .ex_out_valid_i (ex_out_valid),
        .ex_out_ready_o (ex_out_ready),
        .fpr_we_o       (fpr_we),
        .fpr_waddr_o    (fpr_waddr),
        .resp_valid_o   (resp_valid_o),
        .resp_ready_i   (resp_ready_i),
        .resp_rd_o      (resp_rd_o)
    );

    // Operands are read from the registers named by the head
    fpu_ss_exec_unit i_exec_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (ex_in_valid),
        .in_ready_o  (ex_in_ready),
        .op_i        (head_op),
        .opa_i       (rdata_a),
        .opb_i       (rdata_b),
        .data_i      (head_data),
        .out_valid_o (ex_out_valid),
        .out_ready_i (ex_out_ready),
        .out_data_o  (ex_out_data)
    );

    fpu_ss_regfile i_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (head_rs1),
        .raddr_b_i (head_rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (fpr_we),
        .waddr_i   (fpr_waddr),
        .wdata_i   (ex_out_data)
    );

    // Response data is the held unit result
    assign resp_data_o = ex_out_data;

endmodule : fpu_ss

`default_nettype wire

/* logic/fpu_ss_buffer.sv */
/*
 * Instruction FIFO between host issue port and controller.
 * BUF_DEPTH must be a power of two, at least 2. Push and pop may coincide.
 */
`default_nettype none

module fpu_ss_buffer #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Host push side
    input  logic                                 in_valid_i,
    output logic                                 in_ready_o,
    input  fpu_ss_pkg::op_e                      in_op_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]        in_rd_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]        in_rs1_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]        in_rs2_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]        in_data_i,
    // Controller pop side
    output logic                                 pop_valid_o,
    input  logic                                 pop_ready_i,
    output fpu_ss_pkg::op_e                      head_op_o,
    output logic [fpu_ss_pkg::REG_AW-1:0]        head_rd_o,
    output logic [fpu_ss_pkg::REG_AW-1:0]        head_rs1_o,
    output logic [fpu_ss_pkg::REG_AW-1:0]        head_rs2_o,
    output logic [fpu_ss_pkg::DATA_W-1:0]        head_data_o
);

    // Index width plus one wrap bit to tell full from empty
    localparam int unsigned IDX_W = $clog2(BUF_DEPTH);
    localparam int unsigned PTR_W = IDX_W + 1;

    // Entry storage, one array per field
    fpu_ss_pkg::op_e                 op_mem   [BUF_DEPTH];
    logic [fpu_ss_pkg::REG_AW-1:0]   rd_mem   [BUF_DEPTH];
    logic [fpu_ss_pkg::REG_AW-1:0]   rs1_mem  [BUF_DEPTH];
    logic [fpu_ss_pkg::REG_AW-1:0]   rs2_mem  [BUF_DEPTH];
    logic [fpu_ss_pkg::DATA_W-1:0]   data_mem [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    // Same index with different wrap bits means every slot is taken
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]) &&
                   (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]);

    assign in_ready_o  = ~full;
    assign pop_valid_o = ~empty;

    assign push = in_valid_i & in_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    // Head fields come straight out of the slot at the read pointer
    assign head_op_o   = op_mem[rd_ptr_q[IDX_W-1:0]];
    assign head_rd_o   = rd_mem[rd_ptr_q[IDX_W-1:0]];
    assign head_rs1_o  = rs1_mem[rd_ptr_q[IDX_W-1:0]];
    assign head_rs2_o  = rs2_mem[rd_ptr_q[IDX_W-1:0]];
    assign head_data_o = data_mem[rd_ptr_q[IDX_W-1:0]];

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            // Both pointers move independently, so a full buffer can
            // still accept nothing while draining one entry
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Write the incoming instruction into the slot at the write pointer
    always_ff @(posedge clk_i) begin
        if (push) begin
            op_mem[wr_ptr_q[IDX_W-1:0]]   <= in_op_i;
            rd_mem[wr_ptr_q[IDX_W-1:0]]   <= in_rd_i;
            rs1_mem[wr_ptr_q[IDX_W-1:0]]  <= in_rs1_i;
            rs2_mem[wr_ptr_q[IDX_W-1:0]]  <= in_rs2_i;
            data_mem[wr_ptr_q[IDX_W-1:0]] <= in_data_i;
        end
    end

endmodule : fpu_ss_buffer

`default_nettype wire

/* logic/fpu_ss_controller.sv */
/*
 * Offload controller for the instruction at the buffer head.
 * Single issue, in order; retire, writeback and response share one cycle.
 */
`default_nettype none

module fpu_ss_controller (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Buffer head
    input  logic                              pop_valid_i,
    output logic                              pop_ready_o,
    input  fpu_ss_pkg::op_e                   head_op_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     head_rd_i,
    // Execution unit handshakes
    output logic                              ex_in_valid_o,
    input  logic                              ex_in_ready_i,
    input  logic                              ex_out_valid_i,
    output logic                              ex_out_ready_o,
    // Register file write port
    output logic                              fpr_we_o,
    output logic [fpu_ss_pkg::REG_AW-1:0]     fpr_waddr_o,
    // Host response channel
    output logic                              resp_valid_o,
    input  logic                              resp_ready_i,
    output logic [fpu_ss_pkg::REG_AW-1:0]     resp_rd_o
);

    fpu_ss_pkg::ctrl_state_e state_q;
    fpu_ss_pkg::ctrl_state_e state_d;

    logic is_rf_wr;
    logic is_resp;
    logic is_csr;
    logic issue;
    logic result_here;

    // Decode the head opcode into its destination class
    always_comb begin
        is_rf_wr = 1'b0;
        is_resp  = 1'b0;
        is_csr   = 1'b0;
        case (head_op_i)
            fpu_ss_pkg::OP_ADD,
            fpu_ss_pkg::OP_SUB,
            fpu_ss_pkg::OP_MIN,
            fpu_ss_pkg::OP_MAX,
            fpu_ss_pkg::OP_MVWX: is_rf_wr = 1'b1;
            fpu_ss_pkg::OP_MVXW,
            fpu_ss_pkg::OP_LT:   is_resp  = 1'b1;
            fpu_ss_pkg::OP_CSRW: is_csr   = 1'b1;
            default:             is_rf_wr = 1'b0;
        endcase
    end

    // The head goes to the unit once, while it has not been issued yet
    assign ex_in_valid_o = (state_q == fpu_ss_pkg::IDLE) & pop_valid_i;
    assign issue         = ex_in_valid_o & ex_in_ready_i;

    // A finished result that belongs to a valid head
    assign result_here = ex_out_valid_i & pop_valid_i;

    // Response is offered regardless of resp_ready_i so valid never
    // depends on ready; the unit keeps the data stable meanwhile
    assign resp_valid_o = result_here & is_resp;
    assign resp_rd_o    = head_rd_i;

    // Take the result when its destination can absorb it this cycle
    assign ex_out_ready_o = result_here & (is_rf_wr | is_csr | resp_ready_i);

    // Retire the head in the same cycle as the result transfer
    assign pop_ready_o = ex_out_ready_o;

    assign fpr_we_o    = ex_out_ready_o & is_rf_wr;
    assign fpr_waddr_o = head_rd_i;

    // Retire wins over issue, though the two cannot coincide since a
    // result only exists while the head is in flight
    always_comb begin
        state_d = state_q;
        if (pop_ready_o) begin
            state_d = fpu_ss_pkg::IDLE;
        end else if (issue) begin
            state_d = fpu_ss_pkg::INFLIGHT;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= fpu_ss_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : fpu_ss_controller

`default_nettype wire

/* logic/fpu_ss_exec_unit.sv */
/*
 * Stand-in execution unit with integer semantics, not IEEE-754.
 * One operation at a time. ADD/SUB take 2 cycles, the rest take 1.
 */
`default_nettype none

module fpu_ss_exec_unit (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              in_valid_i,
    output logic                              in_ready_o,
    input  fpu_ss_pkg::op_e                   op_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]     opa_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]     opb_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]     data_i,
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output logic [fpu_ss_pkg::DATA_W-1:0]     out_data_o
);

    // Unit occupancy: empty, waiting one more cycle, or holding a result
    typedef enum logic [1:0] {
        EX_EMPTY = 2'd0,
        EX_WAIT  = 2'd1,
        EX_DONE  = 2'd2
    } ex_state_e;

    ex_state_e state_q;

    fpu_ss_pkg::op_e               op_q;
    logic [fpu_ss_pkg::DATA_W-1:0] opa_q;
    logic [fpu_ss_pkg::DATA_W-1:0] opb_q;
    logic [fpu_ss_pkg::DATA_W-1:0] data_q;
    logic [fpu_ss_pkg::DATA_W-1:0] csr_q;
    logic                          accept;
    logic                          two_cycle;

    assign in_ready_o  = (state_q == EX_EMPTY);
    assign out_valid_o = (state_q == EX_DONE);
    assign accept      = in_valid_i & in_ready_o;

    // Add and subtract need the extra cycle
    assign two_cycle = (op_i == fpu_ss_pkg::OP_ADD) || (op_i == fpu_ss_pkg::OP_SUB);

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= EX_EMPTY;
            csr_q   <= '0;
        end else begin
            case (state_q)
                EX_EMPTY: begin
                    if (accept) begin
                        state_q <= two_cycle ? EX_WAIT : EX_DONE;
                    end
                end
                EX_WAIT:  state_q <= EX_DONE;
                EX_DONE: begin
                    if (out_ready_i) begin
                        state_q <= EX_EMPTY;
                    end
                end
                default:  state_q <= EX_EMPTY;
            endcase
            // The control/status register updates at acceptance
            if (accept && (op_i == fpu_ss_pkg::OP_CSRW)) begin
                csr_q <= data_i;
            end
        end
    end

    // Operands are captured once and stay put until the result is taken
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q   <= op_i;
            opa_q  <= opa_i;
            opb_q  <= opb_i;
            data_q <= data_i;
        end
    end

    // Result from the latched operands, stable for the whole DONE phase
    always_comb begin
        case (op_q)
            fpu_ss_pkg::OP_ADD:  out_data_o = opa_q + opb_q;
            fpu_ss_pkg::OP_SUB:  out_data_o = opa_q - opb_q;
            fpu_ss_pkg::OP_MIN:  out_data_o = ($signed(opa_q) < $signed(opb_q)) ? opa_q : opb_q;
            fpu_ss_pkg::OP_MAX:  out_data_o = ($signed(opa_q) < $signed(opb_q)) ? opb_q : opa_q;
            fpu_ss_pkg::OP_LT: begin
                out_data_o = {{(fpu_ss_pkg::DATA_W-1){1'b0}},
                              ($signed(opa_q) < $signed(opb_q))};
            end
            fpu_ss_pkg::OP_MVWX: out_data_o = data_q;
            fpu_ss_pkg::OP_MVXW: out_data_o = opa_q;
            // Echo of the written CSR value, the controller discards it
            fpu_ss_pkg::OP_CSRW: out_data_o = csr_q;
            default:             out_data_o = '0;
        endcase
    end

endmodule : fpu_ss_exec_unit

`default_nettype wire

/* logic/fpu_ss_pkg.sv */
/*
 * Shared widths and encodings for the coprocessor subsystem.
 * Operations are integer stand-ins for FP ops; DATA_W is fixed at 32.
 */
`default_nettype none

package fpu_ss_pkg;

    // Operand and result width, the reference model relies on 32 bits
    localparam int unsigned DATA_W = 32;

    // Register address width, eight floating-point registers
    localparam int unsigned REG_AW = 3;

    // Number of floating-point registers
    localparam int unsigned NUM_REGS = 2 ** REG_AW;

    // Coprocessor opcodes
    // ADD, SUB, MIN, MAX and MVWX write a register
    // MVXW and LT return a value to the host
    // CSRW only updates the control/status register
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MIN  = 3'd2,
        OP_MAX  = 3'd3,
        OP_LT   = 3'd4,
        OP_MVWX = 3'd5,
        OP_MVXW = 3'd6,
        OP_CSRW = 3'd7
    } op_e;

    // Controller state for the instruction at the buffer head
    // IDLE means not yet issued, INFLIGHT means held by the execution unit
    typedef enum logic {
        IDLE     = 1'b0,
        INFLIGHT = 1'b1
    } ctrl_state_e;

endpackage : fpu_ss_pkg

`default_nettype wire

/* logic/fpu_ss_regfile.sv */
/*
 * Eight-entry floating-point register file, 2 read ports, 1 write port.
 * Reads are combinational; a write shows from the next cycle on.
 */
`default_nettype none

module fpu_ss_regfile (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     raddr_a_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     raddr_b_i,
    output logic [fpu_ss_pkg::DATA_W-1:0]     rdata_a_o,
    output logic [fpu_ss_pkg::DATA_W-1:0]     rdata_b_o,
    input  logic                              we_i,
    input  logic [fpu_ss_pkg::REG_AW-1:0]     waddr_i,
    input  logic [fpu_ss_pkg::DATA_W-1:0]     wdata_i
);

    logic [fpu_ss_pkg::DATA_W-1:0] regs_q [fpu_ss_pkg::NUM_REGS];

    // Registers start at zero so early readbacks are defined
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < fpu_ss_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // No write-through bypass, the controller never reads a register
    // in the cycle it is written
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule : fpu_ss_regfile

`default_nettype wire
